/* logic/alu.sv */
`default_nettype none

module alu (
	input wire rvPkg::aluOpT op,
	input wire [rvPkg::xlen-1:0] a,
	input wire [rvPkg::xlen-1:0] b,
	output logic [rvPkg::xlen-1:0] y
);
	import rvPkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0]; // Only the low five bits shift

	always_comb
	begin
		case (op)
			aluSub: y = a - b;
			aluAnd: y = a & b;
			aluOr: y = a | b;
			aluXor: y = a ^ b;
			aluSlt: y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			aluSltu: y = {{(xlen-1){1'b0}}, a < b};
			aluSll: y = a << shamt;
			aluSrl: y = a >> shamt;
			aluSra: y = $signed(a) >>> shamt;
			aluPassB: y = b;
			default: y = a + b;
		endcase
	end

endmodule

`default_nettype wire

/* logic/branchUnit.sv */
`default_nettype none

module branchUnit (
	input wire rvPkg::branchT branch,
	input wire jal,
	input wire jalr,
	input wire [rvPkg::xlen-1:0] a,
	input wire [rvPkg::xlen-1:0] b,
	input wire [rvPkg::xlen-1:0] pc,
	input wire [rvPkg::xlen-1:0] imm,
	input wire [rvPkg::xlen-1:0] aluSum,
	output logic [rvPkg::xlen-1:0] nextPc,
	output logic taken
);
	import rvPkg::*;

	logic condMet;

	always_comb
	begin
		case (branch)
			brEq: condMet = (a == b);
			brNe: condMet = (a != b);
			brLt: condMet = ($signed(a) < $signed(b));
			brGe: condMet = ($signed(a) >= $signed(b));
			brLtu: condMet = (a < b);
			brGeu: condMet = (a >= b);
			default: condMet = 1'b0;
		endcase
	end

	assign taken = condMet || jal || jalr; // Any change of flow

	always_comb
	begin
		if (jalr)
			nextPc = {aluSum[xlen-1:1], 1'b0}; // Target bit 0 dropped
		else if (jal || condMet)
			nextPc = pc + imm;
		else
			nextPc = pc + 32'd4;
	end

endmodule

`default_nettype wire

/* logic/dataMem.sv */
`default_nettype none

module dataMem (
	input wire clk,
	input wire rst,
	input wire we,
	input wire [rvPkg::xlen-1:0] addr,
	input wire [rvPkg::xlen-1:0] wdata,
	input wire [2:0] size,
	output logic [rvPkg::xlen-1:0] rdata
);
	import rvPkg::*;

	logic [xlen-1:0] mem [memWords];
	logic [$clog2(memWords)-1:0] wordIdx;
	logic [3:0] byteEn;
	logic [xlen-1:0] laneData;
	logic [xlen-1:0] shifted;

	assign wordIdx = addr[$clog2(memWords)+1:2]; // Wraps modulo depth

	always_comb
	begin
		case (size[1:0])
			2'b00:
			begin
				byteEn = 4'b0001 << addr[1:0];
				laneData = {4{wdata[7:0]}};
			end
			2'b01:
			begin
				byteEn = addr[1] ? 4'b1100 : 4'b0011;
				laneData = {2{wdata[15:0]}};
			end
			default:
			begin
				byteEn = 4'b1111;
				laneData = wdata;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < memWords; i++)
				mem[i] <= '0;
		end
		else if (we)
		begin
			for (int b = 0; b < 4; b++)
				if (byteEn[b])
					mem[wordIdx][8*b +: 8] <= laneData[8*b +: 8];
		end
	end

	assign shifted = mem[wordIdx] >> {addr[1:0], 3'b000}; // Addressed lane to bit 0

	always_comb
	begin
		case (size)
			3'b000: rdata = {{(xlen-8){shifted[7]}}, shifted[7:0]};
			3'b001: rdata = {{(xlen-16){shifted[15]}}, shifted[15:0]};
			3'b100: rdata = {{(xlen-8){1'b0}}, shifted[7:0]};
			3'b101: rdata = {{(xlen-16){1'b0}}, shifted[15:0]};
			default: rdata = mem[wordIdx];
		endcase
	end

	storeInRange: assert property (@(posedge clk) disable iff (rst)
		we |-> addr[xlen-1:2] < memWords);

endmodule

`default_nettype wire

/* logic/instrDecoder.sv */
`default_nettype none

module instrDecoder (
	input wire [rvPkg::xlen-1:0] instr,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd,
	output logic regWe,
	output logic memWe,
	output logic memRe,
	output logic [2:0] memSize,
	output rvPkg::aluOpT aluOp,
	output logic aluASel,
	output logic aluBImm,
	output rvPkg::branchT branch,
	output logic jal,
	output logic jalr,
	output rvPkg::wbSelT wbSel,
	output logic [rvPkg::xlen-1:0] imm,
	output logic legal
);
	import rvPkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	immT immSel;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];
	assign memSize = funct3; // Size and signedness straight from funct3

	always_comb
	begin
		regWe = 1'b0;
		memWe = 1'b0;
		memRe = 1'b0;
		aluOp = aluAdd;
		aluASel = 1'b0;
		aluBImm = 1'b1;
		branch = brNone;
		jal = 1'b0;
		jalr = 1'b0;
		wbSel = wbAlu;
		immSel = immI;
		legal = 1'b1;
		case (opcode)
			opLoad:
			begin
				regWe = 1'b1;
				memRe = 1'b1;
				wbSel = wbMem;
			end
			opStore:
			begin
				memWe = 1'b1;
				immSel = immS;
			end
			opLui:
			begin
				regWe = 1'b1;
				aluOp = aluPassB;
				immSel = immU;
			end
			opAuipc:
			begin
				regWe = 1'b1;
				aluASel = 1'b1; // PC plus U-immediate
				immSel = immU;
			end
			opOp, opOpImm:
			begin
				regWe = 1'b1;
				aluBImm = (opcode == opOpImm);
				case (funct3)
					3'b000: aluOp = (opcode == opOp && instr[30]) ? aluSub : aluAdd;
					3'b010: aluOp = aluSlt;
					3'b011: aluOp = aluSltu;
					3'b100: aluOp = aluXor;
					3'b110: aluOp = aluOr;
					3'b111: aluOp = aluAnd;
					3'b001:
					begin
						aluOp = aluSll;
						immSel = immShamt;
					end
					default:
					begin
						aluOp = instr[30] ? aluSra : aluSrl;
						immSel = immShamt;
					end
				endcase
			end
			opBranch:
			begin
				aluBImm = 1'b0;
				immSel = immB;
				case (funct3)
					3'b000: branch = brEq;
					3'b001: branch = brNe;
					3'b100: branch = brLt;
					3'b101: branch = brGe;
					3'b110: branch = brLtu;
					3'b111: branch = brGeu;
					default: branch = brNone;
				endcase
			end
			opJal:
			begin
				regWe = 1'b1;
				jal = 1'b1;
				wbSel = wbPc4;
				immSel = immJ;
			end
			opJalr:
			begin
				regWe = 1'b1;
				jalr = 1'b1;
				wbSel = wbPc4; // ALU still forms the target
			end
			default: legal = 1'b0; // Retires as a no-op
		endcase
		if (rd == 5'd0)
			regWe = 1'b0;
	end

	always_comb
	begin
		case (immSel)
			immS: imm = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
			immB: imm = {{(xlen-13){instr[31]}}, instr[31], instr[7], instr[30:25],
				instr[11:8], 1'b0};
			immU: imm = {instr[31:12], 12'b0};
			immJ: imm = {{(xlen-21){instr[31]}}, instr[31], instr[19:12], instr[20],
				instr[30:21], 1'b0};
			immShamt: imm = {{(xlen-5){1'b0}}, instr[24:20]};
			default: imm = {{(xlen-12){instr[31]}}, instr[31:20]};
		endcase
	end

endmodule

`default_nettype wire

/* logic/regFile.sv */
`default_nettype none

module regFile (
	input wire clk,
	input wire rst,
	input wire [4:0] rs1,
	input wire [4:0] rs2,
	input wire [4:0] rd,
	input wire we,
	input wire [rvPkg::xlen-1:0] wd,
	output logic [rvPkg::xlen-1:0] rd1,
	output logic [rvPkg::xlen-1:0] rd2
);
	import rvPkg::*;

	logic [xlen-1:0] regs [1:31]; // x0 has no storage

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && rd != 5'd0)
			regs[rd] <= wd;
	end

	// Old value on a same-cycle write
	assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* logic/rvCore.sv */
`default_nettype none

module rvCore (
	input wire clk,
	input wire rst,
	input wire instrValid,
	input wire [rvPkg::xlen-1:0] instr,
	output logic instrReady,
	output logic retValid,
	input wire retReady,
	output logic [rvPkg::xlen-1:0] retPc,
	output logic [rvPkg::xlen-1:0] retNextPc,
	output logic [4:0] retRd,
	output logic retWe,
	output logic [rvPkg::xlen-1:0] retData
);
	import rvPkg::*;

	logic [xlen-1:0] pc;
	logic [xlen-1:0] pcPlus4;
	logic fire;
	logic [4:0] rs1, rs2, rd;
	logic regWe, memWe, memRe, legal;
	logic [2:0] memSize;
	aluOpT aluOp;
	logic aluASel, aluBImm;
	branchT branch;
	logic jal, jalr;
	wbSelT wbSel;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] rd1, rd2;
	logic [xlen-1:0] aluA, aluB, aluY;
	logic [xlen-1:0] brNextPc;
	logic [xlen-1:0] memRdata;
	logic [xlen-1:0] wbData;
	logic writeRd;

	assign instrReady = !retValid || retReady; // Slot frees as the entry leaves
	assign fire = instrValid && instrReady;
	assign pcPlus4 = pc + 32'd4;
	assign aluA = aluASel ? pc : rd1;
	assign aluB = aluBImm ? imm : rd2;
	assign writeRd = legal && regWe;

	instrDecoder i_decoder (
		.instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .regWe(regWe), .memWe(memWe),
		.memRe(memRe), .memSize(memSize), .aluOp(aluOp), .aluASel(aluASel),
		.aluBImm(aluBImm), .branch(branch), .jal(jal), .jalr(jalr), .wbSel(wbSel),
		.imm(imm), .legal(legal)
	);

	regFile i_regFile (
		.clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
		.we(fire && writeRd), .wd(wbData), .rd1(rd1), .rd2(rd2)
	);

	alu i_alu (.op(aluOp), .a(aluA), .b(aluB), .y(aluY));

	branchUnit i_branchUnit (
		.branch(branch), .jal(jal), .jalr(jalr), .a(rd1), .b(rd2), .pc(pc),
		.imm(imm), .aluSum(aluY), .nextPc(brNextPc), .taken()
	);

	dataMem i_dataMem (
		.clk(clk), .rst(rst), .we(fire && memWe), .addr(aluY), .wdata(rd2),
		.size(memSize), .rdata(memRdata)
	);

	always_comb
	begin
		case (wbSel)
			wbMem: wbData = memRe ? memRdata : '0;
			wbPc4: wbData = pcPlus4; // Link address
			default: wbData = aluY;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= resetPc;
			retValid <= 1'b0;
		end
		else if (fire)
		begin
			pc <= brNextPc;
			retValid <= 1'b1;
		end
		else if (retReady)
			retValid <= 1'b0;
	end

	// Retire payload, loaded only on a transfer
	always_ff @(posedge clk)
	begin
		if (fire)
		begin
			retPc <= pc;
			retNextPc <= brNextPc;
			retRd <= rd;
			retWe <= writeRd;
			retData <= writeRd ? wbData : '0;
		end
	end

	retireHeld: assert property (@(posedge clk) disable iff (rst)
		retValid && !retReady |=> retValid && $stable(retPc) && $stable(retNextPc)
			&& $stable(retRd) && $stable(retWe) && $stable(retData));

endmodule

`default_nettype wire

/* logic/rvPkg.sv */
`default_nettype none

package rvPkg;

	localparam int xlen = 32;
	localparam int memWords = 64; // Data memory depth in words
	localparam logic [xlen-1:0] resetPc = 32'h0000_0000;

	// Major opcodes from instr[6:0]
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;
	localparam logic [6:0] opOp = 7'b0110011;
	localparam logic [6:0] opOpImm = 7'b0010011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluPassB // LUI result
	} aluOpT;

	typedef enum logic [2:0] {
		brNone,
		brEq,
		brNe,
		brLt,
		brGe,
		brLtu,
		brGeu
	} branchT;

	typedef enum logic [2:0] {
		immI,
		immS,
		immB,
		immU,
		immJ,
		immShamt
	} immT;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbPc4 // Link address for JAL and JALR
	} wbSelT;

endpackage

`default_nettype wire

/* project.f */
logic/rvPkg.sv
logic/instrDecoder.sv
logic/alu.sv
logic/regFile.sv
logic/branchUnit.sv
logic/dataMem.sv
logic/rvCore.sv
tests/rvCoreTb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rvCoreTb \
	-f project.f -o rvCoreSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/rvCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
exit 0

/* tests/rvCoreTb.sv */
`default_nettype none

module rvCoreTb;
	import rvPkg::*;

	localparam int maxDirected = 250; // Bound on the directed instruction count
	localparam int numRandom = 300;
	localparam logic [31:0] seed = 32'h50e6;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] nextPc;
		logic [4:0] rd;
		logic we;
		logic [31:0] data;
	} retEntryT;

	logic clk;
	logic rst;
	logic instrValid;
	logic [31:0] instr;
	logic instrReady;
	logic retValid;
	logic retReady;
	logic [31:0] retPc;
	logic [31:0] retNextPc;
	logic [4:0] retRd;
	logic retWe;
	logic [31:0] retData;

	logic [31:0] modelRegs [32];
	logic [31:0] modelMem [memWords];
	logic [31:0] modelPc;
	logic [31:0] drvState;
	logic [31:0] lastNextPc;
	retEntryT expQ [$];
	retEntryT expEntry;
	int errorCount;
	int sentCount;
	int retiredCount;

	rvCore i_rvCore (
		.clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
		.instrReady(instrReady), .retValid(retValid), .retReady(retReady), .retPc(retPc),
		.retNextPc(retNextPc), .retRd(retRd), .retWe(retWe), .retData(retData)
	);

	initial clk = 1'b0;
	always #2 clk = !clk;

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// High bits rotated down since the low LCG bits repeat quickly
	function automatic logic [31:0] drawRand();
		drvState = lcgNext(drvState);
		return {drvState[15:0], drvState[31:16]};
	endfunction

	function automatic logic [4:0] randReg();
		logic [31:0] r;
		r = drawRand();
		return {2'b00, r[2:0]}; // x0 to x7 keeps operands reused
	endfunction

	function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] storeWord(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] branchWord(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] upperWord(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] jalWord(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	// Offset from x0, aligned to the access size and inside the memory
	function automatic logic [11:0] memOffset(input logic [1:0] sz);
		logic [31:0] r;
		logic [31:0] byteOff;
		r = drawRand();
		byteOff = (r % memWords) * 4 + {30'b0, r[17:16]};
		if (sz == 2'd1)
			byteOff[0] = 1'b0;
		else if (sz == 2'd2)
			byteOff[1:0] = 2'b00;
		return byteOff[11:0];
	endfunction

	function automatic logic [31:0] genInstr(input int kind);
		logic [31:0] r;
		logic [2:0] f3;
		logic [11:0] imm;
		r = drawRand();
		f3 = r[2:0];
		case (kind)
			0: return rTypeWord(((f3 == 3'b000 || f3 == 3'b101) && r[3]) ? 7'h20 : 7'h00,
				randReg(), randReg(), f3, randReg(), opOp);
			1:
			begin
				if (f3 == 3'b001)
					imm = {7'h00, r[8:4]};
				else if (f3 == 3'b101)
					imm = {r[3] ? 7'h20 : 7'h00, r[8:4]}; // SRAI or SRLI
				else
					imm = r[31:20];
				return iTypeWord(imm, randReg(), f3, randReg(), opOpImm);
			end
			2:
			begin
				if (f3[1:0] == 2'b11 || f3 == 3'b110)
					f3 = 3'b010;
				return iTypeWord(memOffset(f3[1:0]), 5'd0, f3, randReg(), opLoad);
			end
			3:
			begin
				f3 = {1'b0, r[1:0]};
				if (f3 == 3'b011)
					f3 = 3'b010;
				return storeWord(memOffset(f3[1:0]), randReg(), 5'd0, f3);
			end
			4:
			begin
				if (f3[2:1] == 2'b01)
					f3[2] = 1'b1; // No branch on funct3 010 or 011
				return branchWord({r[30:19], 1'b0}, randReg(), randReg(), f3);
			end
			5: return jalWord({r[31:12], 1'b0}, randReg());
			6: return iTypeWord(r[31:20], randReg(), 3'b000, randReg(), opJalr);
			7: return upperWord(r[31:12], randReg(), r[3] ? opAuipc : opLui);
			default: return {r[31:7], r[4] ? 7'b0001011 : 7'b1110011}; // Unsupported opcodes
		endcase
	endfunction

	// Executes one instruction on the model state, RV32I rules
	function automatic retEntryT refExecute(input logic [31:0] ins);
		retEntryT e;
		logic [6:0] opc;
		logic [2:0] f3;
		logic [31:0] a, b, op2, iImm, sImm, bImm, uImm, jImm, res, addr, lane;
		logic wr, takenBr;
		int idx;
		opc = ins[6:0];
		f3 = ins[14:12];
		a = modelRegs[ins[19:15]];
		b = modelRegs[ins[24:20]];
		iImm = {{20{ins[31]}}, ins[31:20]};
		sImm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		bImm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		uImm = {ins[31:12], 12'b0};
		jImm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		e.pc = modelPc;
		e.nextPc = modelPc + 32'd4;
		e.rd = ins[11:7];
		wr = 1'b0;
		res = '0;
		case (opc)
			opLui:
			begin
				wr = 1'b1;
				res = uImm;
			end
			opAuipc:
			begin
				wr = 1'b1;
				res = modelPc + uImm;
			end
			opJal:
			begin
				wr = 1'b1;
				res = modelPc + 32'd4;
				e.nextPc = modelPc + jImm;
			end
			opJalr:
			begin
				wr = 1'b1;
				res = modelPc + 32'd4;
				e.nextPc = (a + iImm) & ~32'd1;
			end
			opBranch:
			begin
				case (f3)
					3'b000: takenBr = (a == b);
					3'b001: takenBr = (a != b);
					3'b100: takenBr = ($signed(a) < $signed(b));
					3'b101: takenBr = ($signed(a) >= $signed(b));
					3'b110: takenBr = (a < b);
					3'b111: takenBr = (a >= b);
					default: takenBr = 1'b0;
				endcase
				if (takenBr)
					e.nextPc = modelPc + bImm;
			end
			opLoad:
			begin
				wr = 1'b1;
				addr = a + iImm;
				idx = int'(addr[31:2] % memWords);
				lane = modelMem[idx] >> (8 * addr[1:0]);
				case (f3)
					3'b000: res = {{24{lane[7]}}, lane[7:0]};
					3'b001: res = {{16{lane[15]}}, lane[15:0]};
					3'b100: res = {24'b0, lane[7:0]};
					3'b101: res = {16'b0, lane[15:0]};
					default: res = modelMem[idx];
				endcase
			end
			opStore:
			begin
				addr = a + sImm;
				idx = int'(addr[31:2] % memWords);
				case (f3)
					3'b000: modelMem[idx][8 * addr[1:0] +: 8] = b[7:0];
					3'b001: modelMem[idx][16 * addr[1] +: 16] = b[15:0];
					default: modelMem[idx] = b;
				endcase
			end
			opOp, opOpImm:
			begin
				wr = 1'b1;
				op2 = (opc == opOp) ? b : iImm;
				case (f3)
					3'b000: res = (opc == opOp && ins[30]) ? a - b : a + op2;
					3'b001: res = a << op2[4:0];
					3'b010: res = ($signed(a) < $signed(op2)) ? 32'd1 : 32'd0;
					3'b011: res = (a < op2) ? 32'd1 : 32'd0;
					3'b100: res = a ^ op2;
					3'b101:
					begin
						if (ins[30])
							res = $signed(a) >>> op2[4:0]; // Sign bit fills from the left
						else
							res = a >> op2[4:0];
					end
					3'b110: res = a | op2;
					default: res = a & op2;
				endcase
			end
			default: wr = 1'b0; // Unknown opcode is a no-op
		endcase
		if (e.rd == 5'd0)
			wr = 1'b0;
		if (wr)
			modelRegs[e.rd] = res;
		e.we = wr;
		e.data = wr ? res : '0;
		modelPc = e.nextPc;
		return e;
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("Error at time %0t: %s is %h, expected %h", $time, name, got, want);
		errorCount++;
	endtask

	// Starts and ends 1 time unit after a rising edge
	task automatic issue(input logic [31:0] ins);
		logic [31:0] g;
		logic accepted;
		g = drawRand();
		if (g[4:3] == 2'b00)
		begin
			repeat (g[1:0] + 1) @(posedge clk); // Random gap on instrValid
			#1;
		end
		instr = ins;
		instrValid = 1'b1;
		expQ.push_back(refExecute(ins));
		accepted = 1'b0;
		while (!accepted)
		begin
			@(posedge clk);
			accepted = instrReady;
			#1;
		end
		instrValid = 1'b0;
		sentCount++;
	endtask

	task automatic loadReg(input logic [4:0] rd, input logic [31:0] value);
		logic [19:0] upper;
		upper = value[31:12] + {19'b0, value[11]}; // ADDI sign-extends the low part
		issue(upperWord(upper, rd, opLui));
		issue(iTypeWord(value[11:0], rd, 3'b000, rd, opOpImm));
	endtask

	// Back-pressure with ready about three cycles in four
	initial
	begin
		logic [31:0] readyState;
		readyState = lcgNext(seed ^ 32'h0000_ffff);
		retReady = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			readyState = lcgNext(readyState);
			retReady = !rst && readyState[29:28] != 2'b00;
		end
	end

	always @(posedge clk)
	begin
		if (!rst && retValid && retReady)
		begin
			if (expQ.size() == 0)
			begin
				$display("Retire at time %0t with no instruction outstanding", $time);
				errorCount++;
			end
			else
			begin
				expEntry = expQ.pop_front();
				if (retPc !== expEntry.pc)
					reportMismatch("retPc", retPc, expEntry.pc);
				if (retNextPc !== expEntry.nextPc)
					reportMismatch("retNextPc", retNextPc, expEntry.nextPc);
				if (retRd !== expEntry.rd)
					reportMismatch("retRd", {27'b0, retRd}, {27'b0, expEntry.rd});
				if (retWe !== expEntry.we)
					reportMismatch("retWe", {31'b0, retWe}, {31'b0, expEntry.we});
				if (retData !== expEntry.data)
					reportMismatch("retData", retData, expEntry.data);
			end
			if (retPc !== lastNextPc)
				reportMismatch("retPc after previous retNextPc", retPc, lastNextPc);
			lastNextPc = retNextPc;
			retiredCount++;
		end
	end

	initial
	begin
		repeat (4 + (maxDirected + numRandom) * 8 + 200) @(posedge clk);
		$display("Timeout: %0d of %0d instructions retired", retiredCount, sentCount);
		$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		logic [11:0] base;
		logic [31:0] lanes;
		logic [2:0] brF3 [6];
		int k;
		int j;
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		drvState = seed;
		modelPc = resetPc;
		lastNextPc = resetPc;
		errorCount = 0;
		sentCount = 0;
		retiredCount = 0;
		brF3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		for (k = 0; k < 32; k++)
			modelRegs[k] = '0;
		for (k = 0; k < memWords; k++)
			modelMem[k] = '0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// ALU with negative operands
		loadReg(5'd1, 32'hffff_fffb);
		loadReg(5'd2, 32'd7);
		loadReg(5'd3, 32'h8000_0000);
		loadReg(5'd4, 32'hffff_ffff);
		issue(rTypeWord(7'h20, 5'd2, 5'd1, 3'b000, 5'd5, opOp)); // SUB
		issue(rTypeWord(7'h20, 5'd2, 5'd3, 3'b101, 5'd6, opOp)); // SRA
		issue(iTypeWord(12'h41f, 5'd4, 3'b101, 5'd7, opOpImm)); // SRAI by 31
		issue(rTypeWord(7'h00, 5'd2, 5'd1, 3'b010, 5'd5, opOp)); // SLT
		issue(rTypeWord(7'h00, 5'd2, 5'd1, 3'b011, 5'd6, opOp)); // SLTU
		issue(iTypeWord(12'hffe, 5'd4, 3'b010, 5'd7, opOpImm));
		issue(iTypeWord(12'hffe, 5'd1, 3'b011, 5'd7, opOpImm));
		issue(iTypeWord(12'd5, 5'd1, 3'b000, 5'd0, opOpImm)); // Write to x0 dropped
		issue(rTypeWord(7'h00, 5'd0, 5'd0, 3'b000, 5'd5, opOp)); // Reads x0 back
		for (k = 1; k < 8; k++)
			loadReg(5'(k), drawRand());
		for (k = 0; k < 24; k++)
			issue(genInstr(k % 2));

		// Stores then loads of every size in the same word
		for (k = 0; k < 8; k++)
		begin
			loadReg(5'd5, drawRand());
			loadReg(5'd6, drawRand());
			base = memOffset(2'd2);
			lanes = drawRand();
			issue(storeWord(base, 5'd5, 5'd0, 3'b010));
			issue(storeWord(base + {10'b0, lanes[1:0]}, 5'd6, 5'd0, 3'b000));
			issue(storeWord(base + {9'b0, lanes[2], 1'b0}, 5'd6, 5'd0, 3'b001));
			issue(iTypeWord(base + {10'b0, lanes[4:3]}, 5'd0, 3'b000, 5'd7, opLoad));
			issue(iTypeWord(base + {10'b0, lanes[4:3]}, 5'd0, 3'b100, 5'd7, opLoad));
			issue(iTypeWord(base + {9'b0, lanes[5], 1'b0}, 5'd0, 3'b001, 5'd7, opLoad));
			issue(iTypeWord(base + {9'b0, lanes[5], 1'b0}, 5'd0, 3'b101, 5'd7, opLoad));
			issue(iTypeWord(base, 5'd0, 3'b010, 5'd7, opLoad));
		end

		// Branches on less, greater and equal pairs, then jumps
		loadReg(5'd1, 32'hffff_fffb);
		loadReg(5'd2, 32'd7);
		loadReg(5'd3, 32'hffff_fffb);
		for (k = 0; k < 6; k++)
		begin
			lanes = drawRand();
			issue(branchWord({lanes[11:0], 1'b0}, 5'd2, 5'd1, brF3[k]));
			issue(branchWord({lanes[23:12], 1'b0}, 5'd1, 5'd2, brF3[k]));
			issue(branchWord({lanes[31:20], 1'b0}, 5'd3, 5'd1, brF3[k]));
		end
		for (k = 0; k < 4; k++)
		begin
			issue(genInstr(5));
			issue(iTypeWord(memOffset(2'd0), 5'd2, 3'b000, 5'(k + 1), opJalr));
		end

		// Upper immediates and unknown opcodes
		for (k = 0; k < 6; k++)
		begin
			issue(genInstr(7));
			issue(genInstr(8));
		end

		for (j = 0; j < numRandom; j++)
			issue(genInstr(int'(drawRand() % 9)));

		wait (retiredCount == sentCount);
		repeat (3) @(posedge clk);
		if (expQ.size() != 0)
		begin
			$display("%0d expected entries never retired", expQ.size());
			errorCount++;
		end
		if (retiredCount != sentCount)
		begin
			$display("Retired %0d entries for %0d instructions", retiredCount, sentCount);
			errorCount++;
		end
		$display("Retired %0d of %0d instructions, %0d errors", retiredCount, sentCount,
			errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire
